/* logic/addr_map.sv */
`timescale 1ns/1ps

module addr_map #(
   parameter int unsigned SRAM_AW   = 20,
   parameter logic [23:0] SAVE_BASE = 24'hE0000
) (
   input  logic [23:0]        snes_addr,
   input  cart_pkg::map_cfg_t cfg,
   output logic [SRAM_AW-1:0] sram_addr,
   output logic               is_rom,
   output logic               is_save
);

   logic [7:0]  bank;
   logic [23:0] rom_off;
   logic [23:0] save_off;
   logic [23:0] rom_full;
   logic [23:0] save_full;

   assign bank = snes_addr[23:16];

   ////////////////////
   // Region decode
   ////////////////////
   always_comb begin
      if (cfg.mapper == cart_pkg::MAP_HIROM) begin
         // Save RAM at 20-3F:6000-7FFF
         is_save  = (bank >= 8'h20) && (bank <= 8'h3F) &&
                    (snes_addr[15:13] == 3'b011);
         is_rom   = snes_addr[22] | snes_addr[15];
         save_off = {6'd0, bank[4:0], snes_addr[12:0]};
         rom_off  = {2'd0, snes_addr[21:0]};
      end else begin
         // Save RAM at 70-7D lower half, ROM in upper halves
         is_save  = (bank >= 8'h70) && (bank <= 8'h7D) && !snes_addr[15];
         is_rom   = snes_addr[15];
         save_off = {5'd0, bank[3:0], snes_addr[14:0]};
         rom_off  = {2'd0, snes_addr[22:16], snes_addr[14:0]};
      end
   end

   ////////////////////
   // Offsets to SRAM
   ////////////////////
   // Masks follow image size, save area sits above ROM
   assign rom_full  = rom_off & cfg.rom_mask;
   assign save_full = (save_off & cfg.save_mask) + SAVE_BASE;

   // Unmapped space still gets the ROM offset, strobes stay off there
   assign sram_addr = is_save ? save_full[SRAM_AW-1:0] : rom_full[SRAM_AW-1:0];

endmodule

/* logic/cart_core.sv */
`timescale 1ns/1ps

module cart_core #(
   parameter int unsigned SRAM_AW   = 20,
   parameter logic [23:0] SAVE_BASE = 24'hE0000
) (
   input  logic               CLK2,
   input  logic               rst_n,
   // Console bus
   input  logic [23:0]        snes_addr,
   input  logic               rd_n,
   input  logic               wr_n,
   input  logic               cs_n,
   input  logic [7:0]         snes_data_in,
   output logic [7:0]         snes_data_out,
   output logic               snes_data_oe,
   // Microcontroller SPI
   input  logic               sck,
   input  logic               mosi,
   input  logic               ss_n,
   output logic               miso,
   // External SRAM
   output logic [SRAM_AW-1:0] sram_addr,
   output logic [7:0]         sram_wdata,
   output logic               sram_oe_n,
   output logic               sram_we_n,
   input  logic [7:0]         sram_rdata
);

   cart_pkg::map_cfg_t  cfg;
   cart_pkg::mcu_req_t  req;
   cart_pkg::slot_ctl_t ctl;
   logic [SRAM_AW-1:0]  map_addr;
   logic                is_rom;
   logic                is_save;
   logic [7:0]          mcu_rdata;

   spi_cmd_rx u_spi_cmd_rx (
      .CLK2(CLK2), .rst_n(rst_n), .sck(sck), .mosi(mosi), .ss_n(ss_n),
      .miso(miso), .rdata(mcu_rdata), .mcu_done(ctl.mcu_done), .cfg(cfg), .req(req)
   );

   addr_map #(.SRAM_AW(SRAM_AW), .SAVE_BASE(SAVE_BASE)) u_addr_map (
      .snes_addr(snes_addr), .cfg(cfg), .sram_addr(map_addr),
      .is_rom(is_rom), .is_save(is_save)
   );

   slot_sequencer u_slot_sequencer (
      .CLK2(CLK2), .rst_n(rst_n), .rd_n(rd_n), .wr_n(wr_n),
      .is_save(is_save), .req(req), .ctl(ctl)
   );

   sram_datapath #(.SRAM_AW(SRAM_AW)) u_sram_datapath (
      .CLK2(CLK2), .rst_n(rst_n), .ctl(ctl), .map_addr(map_addr), .req(req),
      .snes_data_in(snes_data_in), .sram_rdata(sram_rdata), .sram_addr(sram_addr),
      .sram_wdata(sram_wdata), .snes_data_out(snes_data_out), .mcu_rdata(mcu_rdata)
   );

   assign sram_oe_n = ctl.sram_oe_n;
   assign sram_we_n = ctl.sram_we_n;

   // Drive the console bus only for our own read regions
   assign snes_data_oe = !rd_n && !cs_n && (is_rom || is_save);

endmodule

/* logic/cart_pkg.sv */
package cart_pkg;

   ////////////////////
   // SPI command set
   ////////////////////

   // Opcode is the first byte of every SPI frame
   typedef enum logic [7:0] {
      // Three bytes follow, MSB first
      CMD_SET_ADDR      = 8'h10,
      // One byte follows, bit 0 picks the mapper
      CMD_SET_MAPPER    = 8'h20,
      CMD_SET_ROM_MASK  = 8'h30,
      CMD_SET_SAVE_MASK = 8'h40,
      // Streaming access, address steps per byte
      CMD_READ          = 8'h80,
      CMD_WRITE         = 8'h90
   } cmd_e;

   // Memory layout seen by the console
   typedef enum logic {
      MAP_LOROM = 1'b0,
      MAP_HIROM = 1'b1
   } mapper_e;

   ////////////////////
   // Bus cycle slots
   ////////////////////

   // Slots 0..5 console, 6..11 microcontroller
   typedef enum logic [3:0] {
      SLOT_0    = 4'd0,
      SLOT_1    = 4'd1,
      SLOT_2    = 4'd2,
      SLOT_3    = 4'd3,
      SLOT_4    = 4'd4,
      SLOT_5    = 4'd5,
      SLOT_6    = 4'd6,
      SLOT_7    = 4'd7,
      SLOT_8    = 4'd8,
      SLOT_9    = 4'd9,
      SLOT_10   = 4'd10,
      SLOT_11   = 4'd11,
      SLOT_IDLE = 4'd12
   } slot_e;

   ////////////////////
   // Shared bundles
   ////////////////////

   // Mapper configuration, loaded over SPI
   typedef struct packed {
      mapper_e     mapper;
      logic [23:0] rom_mask;
      logic [23:0] save_mask;
   } map_cfg_t;

   // Pending microcontroller access, held until served
   typedef struct packed {
      logic        valid;
      logic        we;
      logic [23:0] addr;
      logic [7:0]  wdata;
   } mcu_req_t;

   // Sequencer outputs, strobes active low
   typedef struct packed {
      logic snes_phase;
      logic sram_oe_n;
      logic sram_we_n;
      logic snes_capture;
      logic snes_latch;
      logic mcu_latch;
      logic mcu_done;
   } slot_ctl_t;

endpackage

/* logic/slot_sequencer.sv */
`timescale 1ns/1ps

module slot_sequencer (
   input  logic                CLK2,
   input  logic                rst_n,
   input  logic                rd_n,
   input  logic                wr_n,
   input  logic                is_save,
   input  cart_pkg::mcu_req_t  req,
   output cart_pkg::slot_ctl_t ctl
);

   logic [1:0]      rd_sync;
   logic [1:0]      wr_sync;
   // Both strobes high on the previous cycle
   logic            idle_q;
   logic            bus_idle;
   logic            snes_start;
   logic            mcu_start;
   cart_pkg::slot_e slot;
   // Run flags, set at run start or slot 6
   logic            snes_run;
   logic            snes_wr;
   logic            mcu_acc;
   logic            in_snes;
   logic            in_mcu;

   ////////////////////
   // Strobe sync
   ////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         rd_sync <= 2'b11;
         wr_sync <= 2'b11;
         idle_q  <= 1'b1;
      end else begin
         rd_sync <= {rd_sync[0], rd_n};
         wr_sync <= {wr_sync[0], wr_n};
         idle_q  <= bus_idle;
      end
   end

   assign bus_idle = rd_sync[1] & wr_sync[1];
   // Falling edge of rd_n or wr_n starts a console cycle
   assign snes_start = idle_q & ~bus_idle;
   // Idle console, pending request starts its own run
   assign mcu_start = (slot == cart_pkg::SLOT_IDLE) & req.valid;

   ////////////////////
   // Slot counter
   ////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         slot     <= cart_pkg::SLOT_IDLE;
         snes_run <= 1'b0;
         snes_wr  <= 1'b0;
         mcu_acc  <= 1'b0;
      end else if (snes_start) begin
         // Console restarts the run, aborting any half-done access
         slot     <= cart_pkg::SLOT_0;
         snes_run <= 1'b1;
         snes_wr  <= ~wr_sync[1];
         mcu_acc  <= 1'b0;
      end else if (mcu_start) begin
         slot     <= cart_pkg::SLOT_0;
         snes_run <= 1'b0;
         snes_wr  <= 1'b0;
         mcu_acc  <= 1'b0;
      end else begin
         // Request accepted only when slot 6 arrives
         if (slot == cart_pkg::SLOT_5) mcu_acc <= req.valid;
         if (slot == cart_pkg::SLOT_11) mcu_acc <= 1'b0;
         if (slot == cart_pkg::SLOT_11 || slot == cart_pkg::SLOT_IDLE) begin
            slot <= cart_pkg::SLOT_IDLE;
         end else begin
            slot <= cart_pkg::slot_e'(slot + 1'b1);
         end
      end
   end

   assign in_snes = (slot <= cart_pkg::SLOT_5);
   assign in_mcu  = (slot >= cart_pkg::SLOT_6) && (slot <= cart_pkg::SLOT_11);

   ////////////////////
   // Strobe decode
   ////////////////////
   always_comb begin
      ctl              = '0;
      ctl.snes_phase   = ~in_mcu;
      ctl.sram_oe_n    = 1'b1;
      ctl.sram_we_n    = 1'b1;
      if (snes_run && in_snes) begin
         if (snes_wr) begin
            ctl.snes_capture = (slot == cart_pkg::SLOT_0);
            // Only save RAM is writable from the console
            ctl.sram_we_n = ~(is_save && slot >= cart_pkg::SLOT_2 &&
                              slot <= cart_pkg::SLOT_4);
         end else begin
            ctl.sram_oe_n  = 1'b0;
            ctl.snes_latch = (slot == cart_pkg::SLOT_5);
         end
      end
      if (mcu_acc && in_mcu) begin
         if (req.we) begin
            ctl.sram_we_n = ~(slot >= cart_pkg::SLOT_8 && slot <= cart_pkg::SLOT_10);
         end else begin
            ctl.sram_oe_n = 1'b0;
            ctl.mcu_latch = (slot == cart_pkg::SLOT_11);
         end
         ctl.mcu_done = (slot == cart_pkg::SLOT_11);
      end
   end

   // SRAM never sees both strobes at once
   a_strobe_excl: assert property (@(posedge CLK2) disable iff (!rst_n)
      ctl.sram_oe_n || ctl.sram_we_n);

   // Done only for a request the receiver still holds
   a_done_valid: assert property (@(posedge CLK2) disable iff (!rst_n)
      ctl.mcu_done |-> req.valid);

endmodule

/* logic/spi_cmd_rx.sv */
`timescale 1ns/1ps

module spi_cmd_rx (
   input  logic               CLK2,
   input  logic               rst_n,
   input  logic               sck,
   input  logic               mosi,
   input  logic               ss_n,
   output logic               miso,
   input  logic [7:0]         rdata,
   input  logic               mcu_done,
   output cart_pkg::map_cfg_t cfg,
   output cart_pkg::mcu_req_t req
);

   // Where the next byte of the frame goes
   typedef enum logic [2:0] {
      RX_OPCODE,
      RX_ADDR,
      RX_MAPPER,
      RX_ROM_MASK,
      RX_SAVE_MASK,
      RX_READ,
      RX_WRITE,
      RX_IGNORE
   } rx_state_e;

   // Two sync stages, bit 2 of sck is the previous value
   logic [2:0]     sck_sync;
   logic [1:0]     mosi_sync;
   logic [1:0]     ss_sync;
   logic           sck_rise;
   logic           sck_fall;
   logic           frame_off;
   logic [2:0]     bit_cnt;
   logic [6:0]     shift;
   logic           byte_done;
   logic [7:0]     rx_byte;
   cart_pkg::cmd_e opcode;
   rx_state_e      state;
   logic [1:0]     pcnt;
   logic [7:0]     tx_shift;

   ////////////////////
   // Input sync
   ////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         sck_sync  <= 3'b000;
         mosi_sync <= 2'b00;
         ss_sync   <= 2'b11;
      end else begin
         sck_sync  <= {sck_sync[1:0], sck};
         mosi_sync <= {mosi_sync[0], mosi};
         ss_sync   <= {ss_sync[0], ss_n};
      end
   end

   assign sck_rise  = sck_sync[1] & ~sck_sync[2];
   assign sck_fall  = ~sck_sync[1] & sck_sync[2];
   assign frame_off = ss_sync[1];

   // Eighth rising edge closes the byte
   assign byte_done = sck_rise & ~frame_off & (bit_cnt == 3'd7);
   assign rx_byte   = {shift, mosi_sync[1]};
   assign opcode    = cart_pkg::cmd_e'(rx_byte);

   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         bit_cnt <= 3'd0;
      end else if (frame_off) begin
         bit_cnt <= 3'd0;
      end else if (sck_rise) begin
         bit_cnt <= bit_cnt + 3'd1;
      end
   end

   // MOSI shifter, MSB first
   always_ff @(posedge CLK2) begin
      if (sck_rise) begin
         shift <= {shift[5:0], mosi_sync[1]};
      end
   end

   ////////////////////
   // Command decode
   ////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         state         <= RX_OPCODE;
         pcnt          <= 2'd0;
         cfg.mapper    <= cart_pkg::MAP_LOROM;
         cfg.rom_mask  <= '1;
         cfg.save_mask <= '1;
         req           <= '0;
      end else begin
         // Served access drops out, address moves on
         if (mcu_done) begin
            req.valid <= 1'b0;
            req.addr  <= req.addr + 24'd1;
         end
         if (frame_off) begin
            state <= RX_OPCODE;
            pcnt  <= 2'd0;
         end else if (byte_done) begin
            pcnt <= pcnt + 2'd1;
            case (state)
               RX_OPCODE: begin
                  pcnt <= 2'd0;
                  case (opcode)
                     cart_pkg::CMD_SET_ADDR:      state <= RX_ADDR;
                     cart_pkg::CMD_SET_MAPPER:    state <= RX_MAPPER;
                     cart_pkg::CMD_SET_ROM_MASK:  state <= RX_ROM_MASK;
                     cart_pkg::CMD_SET_SAVE_MASK: state <= RX_SAVE_MASK;
                     cart_pkg::CMD_READ: begin
                        // First fetch right at the opcode
                        state     <= RX_READ;
                        req.valid <= 1'b1;
                        req.we    <= 1'b0;
                     end
                     cart_pkg::CMD_WRITE:         state <= RX_WRITE;
                     default:                     state <= RX_IGNORE;
                  endcase
               end
               RX_ADDR: begin
                  req.addr <= {req.addr[15:0], rx_byte};
                  if (pcnt == 2'd2) state <= RX_IGNORE;
               end
               RX_MAPPER: begin
                  cfg.mapper <= cart_pkg::mapper_e'(rx_byte[0]);
                  state      <= RX_IGNORE;
               end
               RX_ROM_MASK: begin
                  cfg.rom_mask <= {cfg.rom_mask[15:0], rx_byte};
                  if (pcnt == 2'd2) state <= RX_IGNORE;
               end
               RX_SAVE_MASK: begin
                  cfg.save_mask <= {cfg.save_mask[15:0], rx_byte};
                  if (pcnt == 2'd2) state <= RX_IGNORE;
               end
               RX_READ: begin
                  // Prefetch for the byte after next
                  req.valid <= 1'b1;
                  req.we    <= 1'b0;
               end
               RX_WRITE: begin
                  req.valid <= 1'b1;
                  req.we    <= 1'b1;
                  req.wdata <= rx_byte;
               end
               default: state <= RX_IGNORE;
            endcase
         end
      end
   end

   ////////////////////
   // MISO
   ////////////////////
   // Byte fetched during the last byte goes out in the next one,
   // so the first byte after CMD_READ is a dummy
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         miso     <= 1'b0;
         tx_shift <= 8'h00;
      end else if (byte_done) begin
         tx_shift <= (state == RX_READ) ? rdata : 8'h00;
      end else if (sck_fall && !frame_off) begin
         miso     <= tx_shift[7];
         tx_shift <= {tx_shift[6:0], 1'b0};
      end else if (frame_off) begin
         miso <= 1'b0;
      end
   end

endmodule

/* logic/sram_datapath.sv */
`timescale 1ns/1ps

module sram_datapath #(
   parameter int unsigned SRAM_AW = 20
) (
   input  logic                CLK2,
   input  logic                rst_n,
   input  cart_pkg::slot_ctl_t ctl,
   input  logic [SRAM_AW-1:0]  map_addr,
   input  cart_pkg::mcu_req_t  req,
   input  logic [7:0]          snes_data_in,
   input  logic [7:0]          sram_rdata,
   output logic [SRAM_AW-1:0]  sram_addr,
   output logic [7:0]          sram_wdata,
   output logic [7:0]          snes_data_out,
   output logic [7:0]          mcu_rdata
);

   // Console write byte, held for the write slots
   logic [7:0] snes_wdata;

   ////////////////////
   // Write side
   ////////////////////
   always_ff @(posedge CLK2) begin
      if (ctl.snes_capture) begin
         snes_wdata <= snes_data_in;
      end
   end

   // Console half uses mapped address, MCU half raw address
   assign sram_addr  = ctl.snes_phase ? map_addr : req.addr[SRAM_AW-1:0];
   assign sram_wdata = ctl.snes_phase ? snes_wdata : req.wdata;

   ////////////////////
   // Read side
   ////////////////////
   // Each side keeps its byte until its next latch pulse
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         snes_data_out <= 8'h00;
         mcu_rdata     <= 8'h00;
      end else begin
         if (ctl.snes_latch) begin
            snes_data_out <= sram_rdata;
         end
         if (ctl.mcu_latch) begin
            mcu_rdata <= sram_rdata;
         end
      end
   end

   // Console and MCU halves never read in the same slot
   a_latch_excl: assert property (@(posedge CLK2) disable iff (!rst_n)
      !(ctl.snes_latch && ctl.mcu_latch));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the cart_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f snes_cart_bridge.f \
   --top-module cart_tb -o cart_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/cart_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
echo "Simulation finished without failures"
exit 0

/* snes_cart_bridge.f */
+incdir+verification
logic/cart_pkg.sv
logic/spi_cmd_rx.sv
logic/addr_map.sv
logic/slot_sequencer.sv
logic/sram_datapath.sv
logic/cart_core.sv
verification/clk_gen.sv
verification/cart_tb.sv

/* verification/cart_tb_tasks.svh */
`ifndef CART_TB_TASKS_SVH
`define CART_TB_TASKS_SVH

////////////////////
// Checks
////////////////////
task automatic check_eq(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
   if (expected !== actual) begin
      error_count++;
      $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first error");
   end
endtask

task automatic report_failure(input string what);
   $display("%s", what);
   $display("CHECKS FAILED");
   $fatal(1, "stopping on failure");
endtask

// Edge plus the input skew
task automatic wait_cycles(input int n);
   repeat (n) @(posedge CLK2);
   #5;
endtask

////////////////////
// SPI master, mode 0
////////////////////
task automatic spi_begin();
   ss_n = 1'b0;
   wait_cycles(SPI_DIV);
endtask

task automatic spi_end();
   wait_cycles(SPI_DIV);
   ss_n = 1'b1;
   wait_cycles(SPI_DIV);
endtask

// MSB first, MISO taken at the rising edge
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
   for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(SPI_DIV);
      sck   = 1'b1;
      rx[i] = miso;
      wait_cycles(SPI_DIV);
      sck = 1'b0;
   end
endtask

// Opcode plus three bytes, MSB first
task automatic spi_cmd24(input logic [7:0] cmd, input logic [23:0] value);
   logic [7:0] rx;
   spi_begin();
   spi_byte(cmd, rx);
   spi_byte(value[23:16], rx);
   spi_byte(value[15:8], rx);
   spi_byte(value[7:0], rx);
   spi_end();
endtask

task automatic spi_cmd8(input logic [7:0] cmd, input logic [7:0] value);
   logic [7:0] rx;
   spi_begin();
   spi_byte(cmd, rx);
   spi_byte(value, rx);
   spi_end();
endtask

////////////////////
// Console bus cycles
////////////////////
// Data and drive enable checked just before rd_n rises
task automatic console_read(input string name, input logic [23:0] addr);
   logic [21:0] m;
   m         = map_ref(addr);
   snes_addr = addr;
   cs_n      = 1'b0;
   rd_n      = 1'b0;
   wait_cycles(20);
   check_eq({name, " data"}, 32'(ref_mem[m[19:0]]), 32'(snes_data_out));
   check_eq({name, " oe"}, 32'(m[21] | m[20]), 32'(snes_data_oe));
   rd_n = 1'b1;
   cs_n = 1'b1;
   wait_cycles(4);
endtask

task automatic console_write(input logic [23:0] addr, input logic [7:0] data);
   logic [21:0] m;
   m            = map_ref(addr);
   snes_addr    = addr;
   snes_data_in = data;
   cs_n         = 1'b0;
   wr_n         = 1'b0;
   wait_cycles(20);
   wr_n = 1'b1;
   cs_n = 1'b1;
   // Only save RAM takes the byte
   if (m[20]) ref_mem[m[19:0]] = data;
   wait_cycles(4);
endtask

`endif

/* verification/cart_tb.sv */
`timescale 1ns/1ps

module cart_tb;

   localparam int          SPI_DIV     = 8;
   localparam int          SRAM_AW     = 20;
   localparam logic [23:0] SAVE_BASE   = 24'hE0000;
   // Bytes over all frames, console cycles over all tests
   localparam int          N_SPI_BYTES = 101;
   localparam int          N_CONSOLE   = 151;
   localparam longint      WATCHDOG_NS = longint'(N_SPI_BYTES * 16 * SPI_DIV +
                                                  N_CONSOLE * 30) * 40 * 2;

   logic               CLK2;
   logic               rst_n;
   logic [23:0]        snes_addr;
   logic               rd_n;
   logic               wr_n;
   logic               cs_n;
   logic [7:0]         snes_data_in;
   logic [7:0]         snes_data_out;
   logic               snes_data_oe;
   logic               sck;
   logic               mosi;
   logic               ss_n;
   logic               miso;
   logic [SRAM_AW-1:0] sram_addr;
   logic [7:0]         sram_wdata;
   logic               sram_oe_n;
   logic               sram_we_n;
   logic [7:0]         sram_rdata;

   // SRAM model and its reference copy
   logic [7:0]  sram_mem [0:(1<<SRAM_AW)-1];
   logic [7:0]  ref_mem  [0:(1<<SRAM_AW)-1];
   logic        ref_hirom;
   logic [23:0] ref_rom_mask;
   logic [23:0] ref_save_mask;
   int          error_count;
   logic [23:0] save_list [0:11];

   // Every address bit reaches the byte
   function automatic logic [7:0] fill_byte(input logic [19:0] a);
      return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]} ^ 8'hA5;
   endfunction

   // Returns {is_rom, is_save, sram address}
   function automatic logic [21:0] map_ref(input logic [23:0] a);
      logic        rom;
      logic        save;
      logic [23:0] off;
      if (ref_hirom) begin
         save = (a[23:16] >= 8'h20) && (a[23:16] <= 8'h3F) && (a[15:13] == 3'b011);
         rom  = a[22] | a[15];
         off  = save ? {6'd0, a[20:16], a[12:0]} : {2'd0, a[21:0]};
      end else begin
         save = (a[23:16] >= 8'h70) && (a[23:16] <= 8'h7D) && !a[15];
         rom  = a[15];
         off  = save ? {5'd0, a[19:16], a[14:0]} : {2'd0, a[22:16], a[14:0]};
      end
      off = save ? ((off & ref_save_mask) + SAVE_BASE) : (off & ref_rom_mask);
      return {rom, save, off[19:0]};
   endfunction

   `include "cart_tb_tasks.svh"

   clk_gen u_clk_gen (
      .CLK2(CLK2),
      .rst_n(rst_n)
   );

   cart_core #(.SRAM_AW(SRAM_AW), .SAVE_BASE(SAVE_BASE)) u_cart_core (
      .CLK2(CLK2), .rst_n(rst_n), .snes_addr(snes_addr), .rd_n(rd_n), .wr_n(wr_n),
      .cs_n(cs_n), .snes_data_in(snes_data_in), .snes_data_out(snes_data_out),
      .snes_data_oe(snes_data_oe), .sck(sck), .mosi(mosi), .ss_n(ss_n), .miso(miso),
      .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_oe_n(sram_oe_n),
      .sram_we_n(sram_we_n), .sram_rdata(sram_rdata)
   );

   ////////////////////
   // SRAM model
   ////////////////////
   // Data bus floats while OE is high
   assign sram_rdata = sram_oe_n ? 8'hxx : sram_mem[sram_addr];

   // Write lands on the rising edge of WE
   always @(posedge sram_we_n) begin
      if (rst_n) sram_mem[sram_addr] = sram_wdata;
   end

   always @(posedge CLK2) begin
      if (rst_n && ($isunknown(sram_oe_n) || $isunknown(sram_we_n)))
         report_failure("SRAM strobes went unknown after reset");
   end

   initial begin
      #(WATCHDOG_NS);
      report_failure("Watchdog expired before the tests finished");
   end

   ////////////////////
   // Test sequence
   ////////////////////
   initial begin
      logic [31:0] r;
      logic [23:0] a;
      logic [23:0] base;
      logic [7:0]  rx;
      logic [21:0] m;
      snes_addr    = '0;
      rd_n         = 1'b1;
      wr_n         = 1'b1;
      cs_n         = 1'b1;
      snes_data_in = '0;
      sck          = 1'b0;
      mosi         = 1'b0;
      ss_n         = 1'b1;
      error_count  = 0;
      ref_hirom    = 1'b0;
      ref_rom_mask  = '1;
      ref_save_mask = '1;
      void'($urandom(74));
      for (int i = 0; i < (1 << SRAM_AW); i++) begin
         sram_mem[i] = fill_byte(20'(i));
         ref_mem[i]  = fill_byte(20'(i));
      end
      @(posedge rst_n);
      wait_cycles(2);

      // Idle state after reset
      check_eq("reset sram_oe_n", 32'd1, 32'(sram_oe_n));
      check_eq("reset sram_we_n", 32'd1, 32'(sram_we_n));
      check_eq("reset snes_data_oe", 32'd0, 32'(snes_data_oe));
      check_eq("reset miso", 32'd0, 32'(miso));

      // Image upload over SPI
      r    = $urandom;
      base = 24'(r[15:0]);
      spi_cmd24(cart_pkg::CMD_SET_ADDR, base);
      spi_begin();
      spi_byte(cart_pkg::CMD_WRITE, rx);
      for (int i = 0; i < 64; i++) begin
         r = $urandom;
         spi_byte(r[7:0], rx);
         ref_mem[base[19:0] + 20'(i)] = r[7:0];
      end
      spi_end();
      wait_cycles(40);
      for (int i = 0; i < 64; i++) begin
         check_eq("upload", 32'(ref_mem[base[19:0] + 20'(i)]),
                  32'(sram_mem[base[19:0] + 20'(i)]));
      end

      // LOROM ROM reads
      r            = $urandom;
      ref_rom_mask = r[23:0];
      spi_cmd24(cart_pkg::CMD_SET_ROM_MASK, ref_rom_mask);
      for (int i = 0; i < 50; i++) begin
         r     = $urandom;
         a     = r[23:0];
         a[15] = 1'b1;
         console_read("lorom rom read", a);
      end

      // LOROM save RAM, then a blocked ROM write
      ref_save_mask = 24'h001FFF;
      spi_cmd24(cart_pkg::CMD_SET_SAVE_MASK, ref_save_mask);
      for (int i = 0; i < 12; i++) begin
         r            = $urandom;
         save_list[i] = {8'h70 + 8'(r[31:16] % 14), 1'b0, r[14:0]};
         console_write(save_list[i], r[22:15]);
      end
      for (int i = 0; i < 12; i++) console_read("lorom save read", save_list[i]);
      r     = $urandom;
      a     = r[23:0];
      a[15] = 1'b1;
      m     = map_ref(a);
      console_write(a, ~ref_mem[m[19:0]]);
      check_eq("rom write blocked", 32'(ref_mem[m[19:0]]), 32'(sram_mem[m[19:0]]));

      // HIROM reads over ROM and save RAM
      spi_cmd8(cart_pkg::CMD_SET_MAPPER, 8'h01);
      ref_hirom = 1'b1;
      for (int i = 0; i < 50; i++) begin
         r = $urandom;
         if (r[31]) begin
            a     = r[23:0];
            a[22] = 1'b1;
         end else begin
            a = {8'h20 + {3'b000, r[20:16]}, 3'b011, r[12:0]};
         end
         console_read("hirom read", a);
      end

      // Console fills save RAM, SPI reads it back under console traffic
      for (int i = 0; i < 16; i++) begin
         r = $urandom;
         console_write({8'h20, 3'b011, 13'(i)}, r[7:0]);
      end
      fork
         begin
            spi_cmd24(cart_pkg::CMD_SET_ADDR, SAVE_BASE);
            spi_begin();
            spi_byte(cart_pkg::CMD_READ, rx);
            // First byte after the opcode carries no data
            for (int j = 1; j < 18; j++) begin
               spi_byte(8'h00, rx);
               if (j >= 2) check_eq("spi readback",
                  32'(ref_mem[SAVE_BASE[19:0] + 20'(j - 2)]), 32'(rx));
            end
            spi_end();
         end
         begin
            // Past the address frame and the read opcode
            wait_cycles(6 * 16 * SPI_DIV);
            for (int k = 0; k < 10; k++) begin
               r     = $urandom;
               a     = r[23:0];
               a[22] = 1'b1;
               console_read("hirom read during spi", a);
            end
         end
      join

      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
   parameter int HALF_NS      = 20,
   parameter int RESET_CYCLES = 2
) (
   output logic CLK2,
   output logic rst_n
);

   // Free running clock, 40 ns period
   initial begin
      CLK2 = 1'b0;
      forever #HALF_NS CLK2 = ~CLK2;
   end

   // Reset held low over the first edges
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge CLK2);
      #5;
      rst_n = 1'b1;
   end

endmodule
